/* hw/fir_pkg.sv */
// fir datapath package: tap counts, word widths and pipeline latencies

package fir_pkg;

    // filter length and folded length of the symmetric taps
    localparam int NTAPS = 16;
    localparam int NHALF = NTAPS / 2;

    // input sample, signed
    localparam int XW = 16;

    // sum of two samples needs one more bit
    localparam int PW = XW + 1;

    // coefficient, signed
    localparam int CW = 12;

    // full product of a pre-add sum and a coefficient
    localparam int MW = PW + CW;

    // output word, room for the sum of NHALF products
    localparam int YW = 32;

    // shift-add multiplier spends one stage per coefficient bit
    localparam int MULT_LAT = CW;

    // delay line + pre-add, multiplier, two adder stages
    localparam int FIR_LAT = 2 + MULT_LAT + 2;

endpackage

/* hw/fir_cfg_pkg.sv */
// fir configuration package: coefficient register map and reset coefficients

package fir_cfg_pkg;

    // one address per folded coefficient
    localparam int CADDR_W = 3;

    // entry k serves taps k and 15-k
    // full response is -32 10 62 121 179 230 269 289 289 269 230 179 121 62 10 -32
    localparam logic signed [fir_pkg::CW-1:0] COEF_RESET [fir_pkg::NHALF] = '{
        -12'sd32,
        12'sd10,
        12'sd62,
        12'sd121,
        12'sd179,
        12'sd230,
        12'sd269,
        12'sd289
    };

endpackage

/* hw/fir_coef_bank.sv */
// fir coefficient bank: eight host-writable signed coefficients with reset defaults

`timescale 1ns/1ns

module fir_coef_bank (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              we,
    input  logic [fir_cfg_pkg::CADDR_W-1:0]   addr,
    input  logic signed [fir_pkg::CW-1:0]     wdata,
    output logic signed [fir_pkg::CW-1:0]     coef [fir_pkg::NHALF]
);
    import fir_cfg_pkg::*;

    // a write is seen by the multipliers from the next edge on
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            coef <= COEF_RESET;
        end else if (we) begin
            coef[addr] <= wdata;
        end
    end

endmodule

/* hw/fir_delay_preadd.sv */
// fir sample delay line with the symmetric pre-adders that fold 16 taps into 8 sums

`timescale 1ns/1ns

module fir_delay_preadd (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          en,
    input  logic signed [fir_pkg::XW-1:0] xin,
    output logic signed [fir_pkg::PW-1:0] pre [fir_pkg::NHALF],
    output logic                          pre_vld
);
    import fir_pkg::*;

    logic signed [XW-1:0] x_q [NTAPS];
    logic                 en_q;

    // history must start at zero so the first outputs see an empty filter
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NTAPS; i++) begin
                x_q[i] <= '0;
            end
        end else if (en) begin
            x_q[0] <= xin;
            for (int i = 1; i < NTAPS; i++) begin
                x_q[i] <= x_q[i-1];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            en_q    <= 1'b0;
            pre_vld <= 1'b0;
        end else begin
            en_q    <= en;
            pre_vld <= en_q;
        end
    end

    // fold taps k and 15-k, both sign extended to PW
    always_ff @(posedge clk) begin
        if (en_q) begin
            for (int k = 0; k < NHALF; k++) begin
                pre[k] <= {x_q[k][XW-1], x_q[k]}
                        + {x_q[NTAPS-1-k][XW-1], x_q[NTAPS-1-k]};
            end
        end
    end

endmodule

/* hw/mult_man.sv */
// pipelined signed shift-add multiplier, one partial product of mult2 per stage

`timescale 1ns/1ns

module mult_man #(
    parameter int A_W = 17,
    parameter int B_W = 12
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        in_rdy,
    input  logic signed [A_W-1:0]       mult1,
    input  logic signed [B_W-1:0]       mult2,
    output logic                        res_rdy,
    output logic signed [A_W+B_W-1:0]   res
);
    localparam int RW = A_W + B_W;

    // operands travel with the running sum, last stage has no use for them
    logic signed [A_W-1:0] a_q   [B_W-1];
    logic        [B_W-1:0] b_q   [B_W-1];
    logic signed [RW-1:0]  acc_q [B_W];
    logic                  vld_q [B_W];

    genvar s;
    generate
        for (s = 0; s < B_W; s++) begin : g_stage
            logic signed [A_W-1:0] a_in;
            logic        [B_W-1:0] b_in;
            logic signed [RW-1:0]  acc_in;
            logic                  vld_in;
            logic signed [RW-1:0]  a_ext;
            logic signed [RW-1:0]  pp;

            if (s == 0) begin : g_first
                assign a_in   = mult1;
                assign b_in   = mult2;
                assign acc_in = '0;
                assign vld_in = in_rdy;
            end else begin : g_next
                assign a_in   = a_q[s-1];
                assign b_in   = b_q[s-1];
                assign acc_in = acc_q[s-1];
                assign vld_in = vld_q[s-1];
            end

            assign a_ext = {{B_W{a_in[A_W-1]}}, a_in};
            assign pp    = b_in[s] ? (a_ext <<< s) : '0;

            always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                    vld_q[s] <= 1'b0;
                end else begin
                    vld_q[s] <= vld_in;
                end
            end

            // sign bit of mult2 carries weight -2^(B_W-1)
            always_ff @(posedge clk) begin
                if (vld_in) begin
                    acc_q[s] <= (s == B_W - 1) ? acc_in - pp : acc_in + pp;
                end
            end

            if (s < B_W - 1) begin : g_carry
                always_ff @(posedge clk) begin
                    if (vld_in) begin
                        a_q[s] <= a_in;
                        b_q[s] <= b_in;
                    end
                end
            end
        end
    endgenerate

    assign res     = acc_q[B_W-1];
    assign res_rdy = vld_q[B_W-1];

endmodule

/* hw/fir_sum_tree.sv */
// fir adder tree: two pipelined stages summing the eight tap products

`timescale 1ns/1ns

module fir_sum_tree #(
    parameter int IN_W  = 29,
    parameter int OUT_W = 32
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      in_vld,
    input  logic signed [IN_W-1:0]    prod [fir_pkg::NHALF],
    output logic                      valid,
    output logic signed [OUT_W-1:0]   yout
);
    import fir_pkg::*;

    localparam int QUAD = NHALF / 2;

    logic signed [OUT_W-1:0] lo_sum;
    logic signed [OUT_W-1:0] hi_sum;
    logic signed [OUT_W-1:0] lo_q;
    logic signed [OUT_W-1:0] hi_q;
    logic                    vld1;

    function automatic logic signed [OUT_W-1:0] sext(input logic signed [IN_W-1:0] v);
        return {{(OUT_W-IN_W){v[IN_W-1]}}, v};
    endfunction

    // lower and upper four products
    always_comb begin
        lo_sum = '0;
        hi_sum = '0;
        for (int i = 0; i < QUAD; i++) begin
            lo_sum = lo_sum + sext(prod[i]);
            hi_sum = hi_sum + sext(prod[QUAD+i]);
        end
    end

    always_ff @(posedge clk) begin
        if (in_vld) begin
            lo_q <= lo_sum;
            hi_q <= hi_sum;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld1  <= 1'b0;
            valid <= 1'b0;
            yout  <= '0;
        end else begin
            vld1  <= in_vld;
            valid <= vld1;
            if (vld1) begin
                yout <= lo_q + hi_q;
            end
        end
    end

endmodule

/* hw/fir_top.sv */
// 16-tap symmetric fir filter top: coefficient bank, delay line, multipliers, adder tree

`timescale 1ns/1ns

module fir_top (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              en,
    input  logic signed [fir_pkg::XW-1:0]     xin,
    input  logic                              cfg_we,
    input  logic [fir_cfg_pkg::CADDR_W-1:0]   cfg_addr,
    input  logic signed [fir_pkg::CW-1:0]     cfg_wdata,
    output logic                              valid,
    output logic signed [fir_pkg::YW-1:0]     yout
);
    import fir_pkg::*;

    logic signed [CW-1:0] coef [NHALF];
    logic signed [PW-1:0] pre  [NHALF];
    logic                 pre_vld;
    logic signed [MW-1:0] prod [NHALF];
    logic                 mult_rdy [NHALF];

    fir_coef_bank u_coef_bank (
        .clk   (clk),
        .rstn  (rstn),
        .we    (cfg_we),
        .addr  (cfg_addr),
        .wdata (cfg_wdata),
        .coef  (coef)
    );

    fir_delay_preadd u_delay_preadd (
        .clk     (clk),
        .rstn    (rstn),
        .en      (en),
        .xin     (xin),
        .pre     (pre),
        .pre_vld (pre_vld)
    );

    // one multiplier per folded tap, all in lockstep
    genvar k;
    generate
        for (k = 0; k < NHALF; k++) begin : g_mult
            mult_man #(
                .A_W (PW),
                .B_W (CW)
            ) u_mult (
                .clk     (clk),
                .rstn    (rstn),
                .in_rdy  (pre_vld),
                .mult1   (pre[k]),
                .mult2   (coef[k]),
                .res_rdy (mult_rdy[k]),
                .res     (prod[k])
            );
        end
    endgenerate

    // multipliers share one strobe, so tap 0 stands for all
    fir_sum_tree #(
        .IN_W  (MW),
        .OUT_W (YW)
    ) u_sum_tree (
        .clk    (clk),
        .rstn   (rstn),
        .in_vld (mult_rdy[0]),
        .prod   (prod),
        .valid  (valid),
        .yout   (yout)
    );

endmodule

/* include/fir_model.svh */
// fir reference model: golden sample history and direct-form convolution

`ifndef FIR_MODEL_SVH
`define FIR_MODEL_SVH

// newest sample sits at index 0, as in the delay line
typedef logic signed [fir_pkg::XW-1:0] fir_hist_t [fir_pkg::NTAPS];
typedef logic signed [fir_pkg::CW-1:0] fir_coef_t [fir_pkg::NHALF];

function automatic fir_hist_t fir_hist_push(input fir_hist_t h,
                                            input logic signed [fir_pkg::XW-1:0] x);
    fir_hist_t n;
    n[0] = x;
    for (int i = 1; i < fir_pkg::NTAPS; i++) begin
        n[i] = h[i-1];
    end
    return n;
endfunction

// taps k and 15-k share bank entry k
function automatic logic signed [fir_pkg::CW-1:0] fir_tap_coef(input fir_coef_t c,
                                                               input int k);
    int idx;
    idx = (k < fir_pkg::NHALF) ? k : fir_pkg::NTAPS - 1 - k;
    return c[idx];
endfunction

function automatic logic signed [fir_pkg::YW-1:0] fir_convolve(input fir_hist_t h,
                                                              input fir_coef_t c);
    logic signed [fir_pkg::YW-1:0] acc;
    logic signed [fir_pkg::YW-1:0] xs;
    logic signed [fir_pkg::YW-1:0] cs;
    acc = '0;
    for (int k = 0; k < fir_pkg::NTAPS; k++) begin
        xs  = h[k];
        cs  = fir_tap_coef(c, k);
        acc = acc + xs * cs;
    end
    return acc;
endfunction

`endif

/* sim/tb_fir.sv */
// fir testbench: drives samples and coefficient writes, checks every result against a golden model

`timescale 1ns/1ns

`include "fir_model.svh"

module tb_fir;
    import fir_pkg::*;
    import fir_cfg_pkg::*;

    localparam int STREAM_N = 64;
    localparam int GAP_N    = 48;
    localparam int DRAIN    = FIR_LAT + 2;

    // two passes of impulse, extremes, stream and gaps, plus the coefficient writes
    localparam int STIM_CYCLES = 8 + 2 * ((2 * NTAPS - 1) + 32 + STREAM_N + GAP_N * 4
                               + 3 * (DRAIN + 1)) + 2 * NHALF + 4;
    localparam int TIMEOUT_NS  = (STIM_CYCLES + FIR_LAT + 50) * 10;

    localparam fir_coef_t COEF_DEFAULT = '{
        -12'sd32, 12'sd10, 12'sd62, 12'sd121, 12'sd179, 12'sd230, 12'sd269, 12'sd289
    };
    localparam fir_coef_t COEF_NEW = '{
        12'sh800, 12'sd2047, -12'sd1, 12'sd5, -12'sd300, 12'sd777, 12'sd1024, -12'sd999
    };

    logic                     clk;
    logic                     rstn;
    logic                     en;
    logic signed [XW-1:0]     xin;
    logic                     cfg_we;
    logic [CADDR_W-1:0]       cfg_addr;
    logic signed [CW-1:0]     cfg_wdata;
    logic                     valid;
    logic signed [YW-1:0]     yout;

    // golden model state
    fir_hist_t                hist;
    fir_coef_t                model_coef;
    logic signed [YW-1:0]     exp_q [$];
    logic signed [YW-1:0]     exp_head;
    int                       exp_cnt;
    logic [FIR_LAT-1:0]       en_pipe;
    logic                     seen_valid;
    int                       seed;

    fir_top dut (
        .clk       (clk),
        .rstn      (rstn),
        .en        (en),
        .xin       (xin),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .valid     (valid),
        .yout      (yout)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_stop();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_value(input string sig, input logic signed [YW-1:0] got,
                                input logic signed [YW-1:0] exp);
        $display("FAIL t=%0t %s got %0d expected %0d", $time, sig, got, exp);
        fail_stop();
    endtask

    task automatic report_error(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        fail_stop();
    endtask

    // model sees inputs and strobes as the DUT samples them at the rising edge
    always @(posedge clk) begin
        if (!rstn) begin
            hist       = '{default: '0};
            model_coef = COEF_DEFAULT;
            exp_q.delete();
            en_pipe    = '0;
            seen_valid = 1'b0;
        end else begin
            if (valid) begin
                if (exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                end
                seen_valid = 1'b1;
            end
            if (cfg_we) begin
                model_coef[cfg_addr] = cfg_wdata;
            end
            if (en) begin
                hist = fir_hist_push(hist, xin);
                exp_q.push_back(fir_convolve(hist, model_coef));
            end
            en_pipe = {en_pipe[FIR_LAT-2:0], en};
        end
        exp_cnt  = exp_q.size();
        exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    // outputs and model state are stable at the falling edge
    a_reset_quiet: assert property (@(negedge clk) !rstn |-> (!valid && yout == '0))
        else report_error("valid or yout not quiet while reset is asserted");

    a_idle_zero: assert property (@(negedge clk) disable iff (!rstn)
        (!seen_valid && !valid) |-> yout == '0)
        else report_value("yout", $sampled(yout), '0);

    a_latency: assert property (@(negedge clk) disable iff (!rstn)
        valid == en_pipe[FIR_LAT-1])
        else report_error("valid does not line up with an en strobe 16 cycles earlier");

    a_no_orphan: assert property (@(negedge clk) disable iff (!rstn) valid |-> exp_cnt > 0)
        else report_error("valid pulse without any sample in flight");

    a_value: assert property (@(negedge clk) disable iff (!rstn) valid |-> yout == exp_head)
        else report_value("yout", $sampled(yout), $sampled(exp_head));

    task automatic send_sample(input logic signed [XW-1:0] x);
        @(posedge clk);
        en  <= 1'b1;
        xin <= x;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            en <= 1'b0;
        end
    endtask

    task automatic drain_pipeline();
        idle_cycles(DRAIN);
        @(negedge clk);
        if (exp_cnt != 0) begin
            report_error("results still pending after the pipeline drained");
        end
    endtask

    // zeros first so the history is clear and the impulse walks the bare taps
    task automatic run_impulse();
        repeat (NTAPS - 1) send_sample(16'sd0);
        send_sample(16'sd1);
        repeat (NTAPS - 1) send_sample(16'sd0);
        drain_pipeline();
    endtask

    task automatic run_stream(input int n);
        logic [31:0] r;
        repeat (16) send_sample(16'sh8000);
        repeat (16) send_sample(16'sh7fff);
        repeat (n) begin
            r = $random(seed);
            send_sample(r[XW-1:0]);
        end
        drain_pipeline();
    endtask

    task automatic run_gapped(input int n);
        logic [31:0] r;
        repeat (n) begin
            r = $random(seed);
            send_sample(r[XW-1:0]);
            r = $random(seed);
            idle_cycles(int'(r[1:0]));
        end
        drain_pipeline();
    endtask

    task automatic write_coefs(input fir_coef_t c);
        for (int i = 0; i < NHALF; i++) begin
            @(posedge clk);
            cfg_we    <= 1'b1;
            cfg_addr  <= CADDR_W'(i);
            cfg_wdata <= c[i];
            @(posedge clk);
            cfg_we    <= 1'b0;
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        report_error("watchdog timeout, the test did not finish in time");
    end

    initial begin
        seed      = 32'h2dec_1c99;
        rstn      = 1'b0;
        en        = 1'b0;
        xin       = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        idle_cycles(2);

        run_impulse();
        run_stream(STREAM_N);
        run_gapped(GAP_N);

        // new coefficients only once nothing is in flight
        write_coefs(COEF_NEW);
        idle_cycles(2);
        run_impulse();
        run_stream(STREAM_N);
        run_gapped(GAP_N);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
hw/fir_pkg.sv
hw/fir_cfg_pkg.sv
hw/fir_coef_bank.sv
hw/fir_delay_preadd.sv
hw/mult_man.sv
hw/fir_sum_tree.sv
hw/fir_top.sv
sim/tb_fir.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fir testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_fir \
        -f tb.f -o vsim_fir > "$BUILD_LOG" 2>&1; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/vsim_fir > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "SIMULATION FAILED" "$SIM_LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

exit 0
